// ==== tb.f ====
src/vec_sram_pkg.sv
src/scrub_counter.sv
src/bank_scrub_ctrl.sv
src/bank_tile.sv
src/bank_row.sv
src/vec_sram_group.sv
verification/tb_clk_gen.sv
verification/vec_sram_group_tb.sv

// ==== verification/vec_sram_group_tb.sv ====
`timescale 1ns/1ps

module vec_sram_group_tb;
    localparam int unsigned ROWS       = vec_sram_pkg::ROWS;
    localparam int unsigned COLS       = vec_sram_pkg::COLS;
    localparam int unsigned LINE_W     = vec_sram_pkg::LINE_W;
    localparam int unsigned SLICE_W    = vec_sram_pkg::SLICE_W;
    localparam int unsigned ENTRY_AW   = vec_sram_pkg::ENTRY_AW;
    localparam int unsigned BLOCK_AW   = vec_sram_pkg::BLOCK_AW;
    localparam int unsigned DEPTH      = 2 ** ENTRY_AW;
    localparam int unsigned SCRUB_LEN  = COLS * DEPTH;
    localparam int unsigned RST_CYCLES = 4;
    localparam int unsigned RAND_OPS   = 24;
    localparam int unsigned MARGIN     = 20;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_WRITE,
        OP_READ
    } op_kind_t;

    typedef struct packed {
        op_kind_t            kind;
        logic [BLOCK_AW-1:0] block;
        logic [ENTRY_AW-1:0] entry;
        logic [LINE_W-1:0]   data;
    } stim_t;

    typedef struct packed {
        logic [31:0]       due;
        logic [LINE_W-1:0] data;
    } exp_rd_t;

    logic                       clk;
    logic                       rst_n;
    vec_sram_pkg::line_cmd_t    cmd;
    vec_sram_pkg::rd_line_t     rd;
    logic                       ready;
    vec_sram_pkg::scrub_state_t ctrl_state;

    stim_t             stim_tab [$];
    exp_rd_t           exp_q [$];
    logic [LINE_W-1:0] ref_mem [COLS][DEPTH];
    integer            seed;
    int unsigned       neg_cnt;
    int unsigned       cycle_cnt;
    int unsigned       cycle_limit;
    int unsigned       scrub_wait;
    int unsigned       mismatch_cnt;
    int unsigned       fail_cnt;
    logic              limit_set;

    tb_clk_gen #(
        .PERIOD_NS  (10),
        .RST_CYCLES (RST_CYCLES)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    vec_sram_group DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .rd    (rd),
        .ready (ready)
    );

    assign ctrl_state = DUT.u_scrub_ctrl.state;

    function automatic logic [LINE_W-1:0] rand_line();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic add_op(input op_kind_t kind, input int blk, input int ent,
                          input logic [LINE_W-1:0] data);
        stim_t s;
        s.kind  = kind;
        s.block = blk[BLOCK_AW-1:0];
        s.entry = ent[ENTRY_AW-1:0];
        s.data  = data;
        stim_tab.push_back(s);
    endtask

    task automatic build_table();
        int unsigned k;
        // never written
        // entry 0 of block 0 also took the discarded write
        add_op(OP_READ, 0, 0, rand_line());
        add_op(OP_READ, 1, 15, rand_line());
        add_op(OP_READ, 0, 7, rand_line());
        add_op(OP_IDLE, 0, 0, '0);
        add_op(OP_WRITE, 0, 3, rand_line());
        add_op(OP_IDLE, 0, 0, '0);
        add_op(OP_READ, 0, 3, rand_line());
        add_op(OP_WRITE, 1, 3, rand_line());
        add_op(OP_READ, 1, 3, rand_line());
        for (int e = 5; e <= 12; e += 2) begin
            add_op(OP_WRITE, 0, e, rand_line());
            add_op(OP_WRITE, 1, e, rand_line());
        end
        // one read per cycle with the block alternating
        for (int e = 3; e <= 12; e += 2) begin
            add_op(OP_READ, 0, e, rand_line());
            add_op(OP_READ, 1, e, rand_line());
        end
        // overwrite and read right behind it
        add_op(OP_WRITE, 1, 7, rand_line());
        add_op(OP_WRITE, 1, 7, rand_line());
        add_op(OP_READ, 1, 7, rand_line());
        add_op(OP_WRITE, 0, 7, rand_line());
        add_op(OP_WRITE, 0, 7, rand_line());
        add_op(OP_READ, 0, 7, rand_line());
        for (int i = 0; i < RAND_OPS; i++) begin
            k = $unsigned($random(seed)) % 3;
            add_op(op_kind_t'(k), $random(seed), $random(seed), rand_line());
        end
    endtask

    task automatic check_rd();
        exp_rd_t e;
        if (exp_q.size() != 0 && exp_q[0].due == neg_cnt) begin
            e = exp_q.pop_front();
            assert (rd.vld === 1'b1) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: rd.vld got %b expected 1", $time, rd.vld);
            end
            for (int r = 0; r < ROWS; r++) begin
                assert (rd.data[r*SLICE_W +: SLICE_W] === e.data[r*SLICE_W +: SLICE_W]) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: rd.data slice %0d got %h expected %h",
                             $time, r, rd.data[r*SLICE_W +: SLICE_W],
                             e.data[r*SLICE_W +: SLICE_W]);
                end
            end
        end else begin
            assert (rd.vld === 1'b0) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: rd.vld got %b expected 0", $time, rd.vld);
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        neg_cnt++;
        check_rd();
    endtask

    // the model is updated in issue order just like the DUT
    task automatic drive_op(input stim_t s);
        exp_rd_t e;
        cmd = '0;
        case (s.kind)
            OP_WRITE: begin
                cmd.vld   = 1'b1;
                cmd.wr    = 1'b1;
                cmd.block = s.block;
                cmd.entry = s.entry;
                cmd.data  = s.data;
                ref_mem[s.block][s.entry] = s.data;
            end
            OP_READ: begin
                cmd.vld   = 1'b1;
                cmd.wr    = 1'b0;
                cmd.block = s.block;
                cmd.entry = s.entry;
                cmd.data  = s.data;
                e.due     = neg_cnt + COLS;
                e.data    = ref_mem[s.block][s.entry];
                exp_q.push_back(e);
            end
            default: begin
                cmd = '0;
            end
        endcase
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        wait (limit_set === 1'b1);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, ready=%b, scrub state %s",
                 cycle_limit, ready, ctrl_state.name());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        cmd          = '0;
        seed         = 32'hdd997e52;
        neg_cnt      = 0;
        scrub_wait   = 0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        limit_set    = 1'b0;
        for (int b = 0; b < COLS; b++) begin
            for (int e = 0; e < DEPTH; e++) begin
                ref_mem[b][e] = '0;
            end
        end
        build_table();
        cycle_limit = RST_CYCLES + SCRUB_LEN + 2 + stim_tab.size() + COLS + MARGIN;
        limit_set   = 1'b1;

        // reset is released on the last of these falling edges
        @(posedge clk);
        repeat (RST_CYCLES) begin
            step();
            assert (ready === 1'b0) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: ready got %b expected 0", $time, ready);
            end
        end

        // keep a write to block 0 entry 0 on the bus until ready
        while (ready !== 1'b1) begin
            cmd.vld   = 1'b1;
            cmd.wr    = 1'b1;
            cmd.block = '0;
            cmd.entry = '0;
            cmd.data  = rand_line() | 64'h1;
            step();
            scrub_wait++;
        end
        cmd = '0;
        $display("ready seen %0d cycles after reset release", scrub_wait);

        foreach (stim_tab[i]) begin
            drive_op(stim_tab[i]);
            step();
            assert (ready === 1'b1) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: ready got %b expected 1", $time, ready);
            end
        end
        cmd = '0;
        repeat (COLS + 1) step();
        assert (exp_q.size() == 0) else begin
            fail_cnt++;
            $display("%0d expected reads never came back", exp_q.size());
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS  = 10,
    parameter int unsigned RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

    // release on a falling edge, away from the flops' sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== src/vec_sram_group.sv ====
`timescale 1ns/1ps

module vec_sram_group (
    input  logic                    clk,
    input  logic                    rst_n,
    input  vec_sram_pkg::line_cmd_t cmd,
    output vec_sram_pkg::rd_line_t  rd,
    output logic                    ready
);
    localparam int unsigned ROWS    = vec_sram_pkg::ROWS;
    localparam int unsigned SLICE_W = vec_sram_pkg::SLICE_W;

    vec_sram_pkg::line_cmd_t  grid_cmd;
    vec_sram_pkg::slice_cmd_t row_cmd [ROWS];
    vec_sram_pkg::rd_slice_t  row_rd  [ROWS];
    logic [ROWS-1:0]          row_vld;

    bank_scrub_ctrl u_scrub_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .grid_cmd (grid_cmd),
        .ready    (ready)
    );

    // same command to every row, each with its own slice of the line
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            row_cmd[r].vld   = grid_cmd.vld;
            row_cmd[r].wr    = grid_cmd.wr;
            row_cmd[r].block = grid_cmd.block;
            row_cmd[r].entry = grid_cmd.entry;
            row_cmd[r].data  = grid_cmd.data[r*SLICE_W +: SLICE_W];
        end
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        bank_row u_row (
            .clk   (clk),
            .rst_n (rst_n),
            .cmd   (row_cmd[r]),
            .rd    (row_rd[r])
        );
    end

    // row 0 holds the low slice
    always_comb begin
        rd.vld  = row_rd[0].vld;
        rd.data = '0;
        for (int r = 0; r < ROWS; r++) begin
            rd.data[r*SLICE_W +: SLICE_W] = row_rd[r].data;
        end
    end

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            row_vld[r] = row_rd[r].vld;
        end
    end

    a_rows_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (row_vld == '0) || (row_vld == '1)
    );

endmodule

// ==== src/bank_row.sv ====
`timescale 1ns/1ps

module bank_row (
    input  logic                     clk,
    input  logic                     rst_n,
    input  vec_sram_pkg::slice_cmd_t cmd,
    output vec_sram_pkg::rd_slice_t  rd
);
    localparam int unsigned COLS = vec_sram_pkg::COLS;

    // index j is the west side of column j
    vec_sram_pkg::slice_cmd_t cmd_hop [COLS+1];
    vec_sram_pkg::rd_slice_t  rd_hop  [COLS+1];

    assign cmd_hop[0] = cmd;
    assign rd_hop[0]  = '0;

    for (genvar j = 0; j < COLS; j++) begin : g_col
        bank_tile #(
            .BLOCK_ID (j)
        ) u_tile (
            .clk      (clk),
            .rst_n    (rst_n),
            .west_cmd (cmd_hop[j]),
            .east_cmd (cmd_hop[j+1]),
            .west_rd  (rd_hop[j]),
            .east_rd  (rd_hop[j+1])
        );
    end

    assign rd = rd_hop[COLS];

    // a read leaves the east edge together with its own command
    a_rd_with_cmd: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.vld == (cmd_hop[COLS].vld && !cmd_hop[COLS].wr)
    );

endmodule

// ==== src/bank_tile.sv ====
`timescale 1ns/1ps

module bank_tile #(
    parameter int unsigned BLOCK_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  vec_sram_pkg::slice_cmd_t west_cmd,
    output vec_sram_pkg::slice_cmd_t east_cmd,
    input  vec_sram_pkg::rd_slice_t  west_rd,
    output vec_sram_pkg::rd_slice_t  east_rd
);
    localparam int unsigned SLICE_W  = vec_sram_pkg::SLICE_W;
    localparam int unsigned BLOCK_AW = vec_sram_pkg::BLOCK_AW;
    localparam int unsigned DEPTH    = 2 ** vec_sram_pkg::ENTRY_AW;
    localparam logic [BLOCK_AW-1:0] MY_BLOCK = BLOCK_AW'(BLOCK_ID);

    logic [SLICE_W-1:0]       mem [DEPTH];

    logic                     hit;
    logic                     hit_wr;
    logic                     hit_rd;

    logic                     cmd_vld_q;
    vec_sram_pkg::slice_cmd_t cmd_q;
    logic                     rd_vld_q;
    logic [SLICE_W-1:0]       rd_data_q;

    assign hit    = west_cmd.vld && (west_cmd.block == MY_BLOCK);
    assign hit_wr = hit && west_cmd.wr;
    assign hit_rd = hit && !west_cmd.wr;

    // slice storage
    always_ff @(posedge clk) begin
        if (hit_wr) begin
            mem[west_cmd.entry] <= west_cmd.data;
        end
    end

    // command hop to the east neighbour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_vld_q <= 1'b0;
        end else begin
            cmd_vld_q <= west_cmd.vld;
        end
    end

    always_ff @(posedge clk) begin
        if (west_cmd.vld) begin
            cmd_q <= west_cmd;
        end
    end

    always_comb begin
        east_cmd     = cmd_q;
        east_cmd.vld = cmd_vld_q;
    end

    // local read result or the one coming from the west, never both
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= hit_rd || west_rd.vld;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_rd) begin
            rd_data_q <= mem[west_cmd.entry];
        end else if (west_rd.vld) begin
            rd_data_q <= west_rd.data;
        end
    end

    assign east_rd = '{vld: rd_vld_q, data: rd_data_q};

    // results from upstream tiles travel in step with the command stream
    a_no_rd_collision: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(hit_rd && west_rd.vld)
    );

endmodule

// ==== src/bank_scrub_ctrl.sv ====
`timescale 1ns/1ps

module bank_scrub_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  vec_sram_pkg::line_cmd_t cmd,
    output vec_sram_pkg::line_cmd_t grid_cmd,
    output logic                    ready
);
    localparam int unsigned ENTRY_AW    = vec_sram_pkg::ENTRY_AW;
    localparam int unsigned AW          = vec_sram_pkg::BLOCK_AW + ENTRY_AW;
    localparam int unsigned SCRUB_COUNT = vec_sram_pkg::COLS * (2 ** ENTRY_AW);

    vec_sram_pkg::scrub_state_t state;
    vec_sram_pkg::scrub_state_t state_nxt;
    logic                       scrub_en;
    logic [AW-1:0]              scrub_addr;
    logic                       scrub_last;

    // block number sits in the upper address bits
    scrub_counter #(
        .COUNT (SCRUB_COUNT)
    ) u_scrub_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (scrub_en),
        .addr  (scrub_addr),
        .last  (scrub_last)
    );

    assign scrub_en = (state == vec_sram_pkg::SCRUB);

    always_comb begin
        state_nxt = state;
        case (state)
            vec_sram_pkg::IDLE: begin
                state_nxt = vec_sram_pkg::SCRUB;
            end
            vec_sram_pkg::SCRUB: begin
                if (scrub_last) begin
                    state_nxt = vec_sram_pkg::READY;
                end
            end
            default: begin
                state_nxt = vec_sram_pkg::READY;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= vec_sram_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // external commands are dropped until the scrub has finished
    always_comb begin
        grid_cmd = '0;
        case (state)
            vec_sram_pkg::SCRUB: begin
                grid_cmd.vld   = 1'b1;
                grid_cmd.wr    = 1'b1;
                grid_cmd.block = scrub_addr[AW-1:ENTRY_AW];
                grid_cmd.entry = scrub_addr[ENTRY_AW-1:0];
            end
            vec_sram_pkg::READY: begin
                grid_cmd = cmd;
            end
            default: begin
                grid_cmd = '0;
            end
        endcase
    end

    assign ready = (state == vec_sram_pkg::READY);

    // anything other than a write of zeros is external and needs a finished scrub
    a_ext_only_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        (grid_cmd.vld && !(grid_cmd.wr && grid_cmd.data == '0)) |-> (ready && scrub_last)
    );

endmodule

// ==== src/scrub_counter.sv ====
`timescale 1ns/1ps

module scrub_counter #(
    parameter int unsigned COUNT = 32
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   en,
    output logic [vec_sram_pkg::BLOCK_AW+vec_sram_pkg::ENTRY_AW-1:0] addr,
    output logic                                                   last
);
    localparam int unsigned AW = vec_sram_pkg::BLOCK_AW + vec_sram_pkg::ENTRY_AW;
    localparam logic [AW-1:0] LAST_ADDR = AW'(COUNT - 1);

    // stops on the final address and stays there
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (en && !last) begin
            addr <= addr + 1'b1;
        end
    end

    assign last = (addr == LAST_ADDR);

    // the address only climbs and never wraps back past the final count
    a_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (addr <= LAST_ADDR) && ($stable(addr) || (addr > $past(addr)))
    );

endmodule

// ==== src/vec_sram_pkg.sv ====
package vec_sram_pkg;

    // grid shape
    localparam int unsigned ROWS     = 4;
    localparam int unsigned COLS     = 2;

    localparam int unsigned LINE_W   = 64;
    localparam int unsigned SLICE_W  = LINE_W / ROWS;
    localparam int unsigned ENTRY_AW = 4;
    localparam int unsigned BLOCK_AW = 1;

    // command as it arrives at the west edge, full line
    typedef struct packed {
        logic                vld;
        logic                wr;
        logic [BLOCK_AW-1:0] block;
        logic [ENTRY_AW-1:0] entry;
        logic [LINE_W-1:0]   data;
    } line_cmd_t;

    // per-row copy of the command, one slice of write data
    typedef struct packed {
        logic                vld;
        logic                wr;
        logic [BLOCK_AW-1:0] block;
        logic [ENTRY_AW-1:0] entry;
        logic [SLICE_W-1:0]  data;
    } slice_cmd_t;

    typedef struct packed {
        logic               vld;
        logic [SLICE_W-1:0] data;
    } rd_slice_t;

    typedef struct packed {
        logic              vld;
        logic [LINE_W-1:0] data;
    } rd_line_t;

    typedef enum logic [1:0] {
        IDLE,
        SCRUB,
        READY
    } scrub_state_t;

endpackage
